// File: invMixColumns.f
+incdir+bench
src/invMixPkg.sv
src/invMixColumn.sv
src/invMixEngine.sv
src/axiLiteWriteSide.sv
src/axiLiteReadSide.sv
src/invMixColumnsTop.sv
bench/invMixTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f invMixColumns.f --top-module invMixTb -o invMixSim

output=$(./obj_dir/invMixSim)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
  exit 0
else
  exit 1
fi

// File: bench/invMixRef.svh
// multiply in GF(2^8) by shifting and adding, with reduction by x^8 + x^4 + x^3 + x + 1.
function automatic logic [7:0] shiftAddMul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] product;
  logic [7:0] addend;
  product = 8'h00;
  addend = a;
  for (int k = 0; k < 8; k++) begin
    if (b[k]) begin
      product = product ^ addend;
    end
    addend = addend[7] ? ({addend[6:0], 1'b0} ^ 8'h1b) : {addend[6:0], 1'b0};
  end
  return product;
endfunction

// the top byte of the word is row 0 of the column.
function automatic logic [31:0] refInvMixColumn(input logic [31:0] col);
  logic [7:0] inBytes [4];
  logic [7:0] outBytes [4];
  logic [7:0] coef [4];
  coef[0] = 8'h0e;
  coef[1] = 8'h0b;
  coef[2] = 8'h0d;
  coef[3] = 8'h09;
  for (int c = 0; c < 4; c++) begin
    inBytes[c] = col[31 - 8 * c -: 8];
  end
  for (int r = 0; r < 4; r++) begin
    outBytes[r] = 8'h00;
    for (int c = 0; c < 4; c++) begin
      outBytes[r] = outBytes[r] ^ shiftAddMul(inBytes[c], coef[(c - r + 4) % 4]);
    end
  end
  return {outBytes[0], outBytes[1], outBytes[2], outBytes[3]};
endfunction

// both tasks start and end 1 ns after a rising edge.
task automatic writeWord(input logic [7:0] addr, input logic [31:0] data,
                         input int stall, output logic [1:0] resp);
  awaddr = addr;
  wdata = data;
  awvalid = 1'b1;
  wvalid = 1'b1;
  bready = 1'b0;
  do begin
    @(posedge clk);
    #1;
  end while (!awready);
  expectWord("wready", 32'h1, 32'(wready));
  @(posedge clk);
  #1;
  awvalid = 1'b0;
  wvalid = 1'b0;
  // the address and data move on once taken, so a held response must not follow them.
  awaddr = ~addr;
  wdata = ~data;
  while (!bvalid) begin
    @(posedge clk);
    #1;
  end
  resp = bresp;
  repeat (stall) begin
    @(posedge clk);
    #1;
    expectWord("bvalid", 32'h1, 32'(bvalid));
    expectWord("bresp", 32'(resp), 32'(bresp));
  end
  bready = 1'b1;
  @(posedge clk);
  #1;
  bready = 1'b0;
endtask

task automatic readWord(input logic [7:0] addr, input int stall,
                        output logic [31:0] data, output logic [1:0] resp);
  araddr = addr;
  arvalid = 1'b1;
  rready = 1'b0;
  do begin
    @(posedge clk);
    #1;
  end while (!arready);
  @(posedge clk);
  #1;
  arvalid = 1'b0;
  araddr = ~addr;
  while (!rvalid) begin
    @(posedge clk);
    #1;
  end
  data = rdata;
  resp = rresp;
  repeat (stall) begin
    @(posedge clk);
    #1;
    expectWord("rvalid", 32'h1, 32'(rvalid));
    expectWord("rdata", data, rdata);
    expectWord("rresp", 32'(resp), 32'(rresp));
  end
  rready = 1'b1;
  @(posedge clk);
  #1;
  rready = 1'b0;
endtask

// File: bench/invMixTb.sv
`timescale 1ns/1ps

module invMixTb;
  import invMixPkg::*;

  localparam int NumColumns = 4;
  localparam int RandomRuns = 20;
  // a run writes and reads every column, starts once and polls status a few times.
  localparam int RunTransactions = 3 * NumColumns + 4;
  localparam int TransactionCount = (RandomRuns + 4) * RunTransactions + 32;
  localparam int WatchdogCycles = TransactionCount * 40 + 1000;

  logic clk;
  logic reset;
  logic [7:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [7:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  logic [31:0] stateCols [NumColumns];
  logic [31:0] nextCols [NumColumns];
  int errorCount;
  int checkCount;

  // observed values wait here until the comparison process takes them.
  string nameQ [$];
  logic [31:0] expectedQ [$];
  logic [31:0] gotQ [$];
  time timeQ [$];
  string cmpName;
  logic [31:0] cmpExpected;
  logic [31:0] cmpGot;
  time cmpTime;

  invMixColumnsTop #(
    .NumColumns(NumColumns)
  ) DUT (
    .clk(clk),
    .reset(reset),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready)
  );

  always #10 clk = ~clk;

  function automatic void expectWord(input string name, input logic [31:0] expected,
                                     input logic [31:0] got);
    nameQ.push_back(name);
    expectedQ.push_back(expected);
    gotQ.push_back(got);
    timeQ.push_back($time);
  endfunction

  function automatic logic [7:0] wordToAddr(input int word);
    return 8'(word * 4);
  endfunction

  `include "invMixRef.svh"

  always @(negedge clk) begin
    while (gotQ.size() > 0) begin
      cmpName = nameQ.pop_front();
      cmpExpected = expectedQ.pop_front();
      cmpGot = gotQ.pop_front();
      cmpTime = timeQ.pop_front();
      checkCount++;
      assert (cmpGot === cmpExpected) else begin
        errorCount++;
        $display("FAIL time %0t %s got %h expected %h", cmpTime, cmpName, cmpGot, cmpExpected);
      end
    end
  end

  task automatic writeState();
    logic [1:0] resp;
    for (int i = 0; i < NumColumns; i++) begin
      writeWord(wordToAddr(StateBase + i), stateCols[i], $urandom_range(2, 0), resp);
      expectWord("bresp state write", 32'(RespOkay), 32'(resp));
    end
  endtask

  task automatic startRun();
    logic [1:0] resp;
    writeWord(wordToAddr(ControlAddr), 32'h1, 0, resp);
    expectWord("bresp control write", 32'(RespOkay), 32'(resp));
  endtask

  // polls the status register until done is seen, however long the run takes.
  task automatic waitDone();
    logic [31:0] data;
    logic [1:0] resp;
    do begin
      readWord(wordToAddr(StatusAddr), 0, data, resp);
    end while (!data[1]);
    expectWord("status when done", 32'h2, data);
  endtask

  task automatic checkResults();
    logic [31:0] data;
    logic [1:0] resp;
    for (int i = 0; i < NumColumns; i++) begin
      readWord(wordToAddr(ResultBase + i), $urandom_range(2, 0), data, resp);
      expectWord($sformatf("rdata result %0d", i), refInvMixColumn(stateCols[i]), data);
      expectWord("rresp result", 32'(RespOkay), 32'(resp));
    end
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles without the test finishing", WatchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] data;
    logic [1:0] resp;
    void'($urandom(32'hd4c));
    clk = 1'b0;
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = 4'hf;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    errorCount = 0;
    checkCount = 0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    readWord(wordToAddr(StatusAddr), 0, data, resp);
    expectWord("status after reset", 32'h0, data);

    // an all-equal byte column maps to itself, since 14^11^13^9 is 1.
    stateCols[0] = 32'h8e4da1bc;
    stateCols[1] = 32'h01010101;
    stateCols[2] = 32'hc6c6c6c6;
    stateCols[3] = 32'hd4d4d4d4;
    writeState();
    startRun();
    readWord(wordToAddr(StatusAddr), 0, data, resp);
    expectWord("status while busy", 32'h1, data);
    waitDone();
    readWord(wordToAddr(ResultBase), 0, data, resp);
    expectWord("rdata known vector", 32'hdb135345, data);
    for (int i = 1; i < NumColumns; i++) begin
      readWord(wordToAddr(ResultBase + i), 0, data, resp);
      expectWord("rdata identity column", stateCols[i], data);
    end
    checkResults();

    for (int run = 0; run < RandomRuns; run++) begin
      for (int i = 0; i < NumColumns; i++) begin
        stateCols[i] = $urandom;
      end
      writeState();
      startRun();
      waitDone();
      checkResults();
    end

    // the last column is rewritten first and lands before the engine reaches it.
    for (int i = 0; i < NumColumns; i++) begin
      stateCols[i] = $urandom;
      nextCols[i] = $urandom;
    end
    writeState();
    startRun();
    for (int i = NumColumns - 1; i >= 0; i--) begin
      writeWord(wordToAddr(StateBase + i), nextCols[i], 0, resp);
    end
    waitDone();
    checkResults();
    for (int i = 0; i < NumColumns; i++) begin
      stateCols[i] = nextCols[i];
    end
    startRun();
    waitDone();
    checkResults();

    writeWord(wordToAddr(StateBase + NumColumns), 32'hdeadbeef, 0, resp);
    expectWord("bresp unmapped write", 32'(RespSlvErr), 32'(resp));
    writeWord(wordToAddr(ResultBase), 32'hdeadbeef, 0, resp);
    expectWord("bresp result write", 32'(RespSlvErr), 32'(resp));
    readWord(wordToAddr(40), 0, data, resp);
    expectWord("rresp unmapped read", 32'(RespSlvErr), 32'(resp));
    expectWord("rdata unmapped read", 32'h0, data);
    readWord(wordToAddr(ResultBase + NumColumns), 0, data, resp);
    expectWord("rresp unmapped result", 32'(RespSlvErr), 32'(resp));
    expectWord("rdata unmapped result", 32'h0, data);
    readWord(wordToAddr(StateBase), 0, data, resp);
    expectWord("rdata state readback", stateCols[0], data);
    expectWord("rresp state readback", 32'(RespOkay), 32'(resp));
    checkResults();

    for (int i = 0; i < 4; i++) begin
      nextCols[0] = $urandom;
      writeWord(wordToAddr(StateBase + 1), nextCols[0], $urandom_range(8, 3), resp);
      expectWord("bresp stalled write", 32'(RespOkay), 32'(resp));
      readWord(wordToAddr(StateBase + 1), $urandom_range(8, 3), data, resp);
      expectWord("rdata stalled read", nextCols[0], data);
      expectWord("rresp stalled read", 32'(RespOkay), 32'(resp));
    end

    while (gotQ.size() != 0) @(posedge clk);
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src/invMixColumnsTop.sv
`timescale 1ns/1ps

module invMixColumnsTop #(
  parameter int NumColumns = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic [invMixPkg::AxiAddrWidth-1:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [invMixPkg::AxiDataWidth-1:0] wdata,
  input  logic [3:0] wstrb,
  input  logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input  logic bready,
  input  logic [invMixPkg::AxiAddrWidth-1:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic [invMixPkg::AxiDataWidth-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input  logic rready
);

  logic [NumColumns*invMixPkg::ColumnWidth-1:0] stateColumns;
  logic [NumColumns*invMixPkg::ColumnWidth-1:0] resultColumns;
  logic start;
  logic busy;
  logic done;

  axiLiteWriteSide #(
    .NumColumns(NumColumns)
  ) writeSide (
    .clk(clk),
    .reset(reset),
    .awaddr(awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata(wdata),
    .wstrb(wstrb),
    .wvalid(wvalid),
    .wready(wready),
    .bresp(bresp),
    .bvalid(bvalid),
    .bready(bready),
    .stateColumns(stateColumns),
    .start(start)
  );

  invMixEngine #(
    .NumColumns(NumColumns)
  ) engine (
    .clk(clk),
    .reset(reset),
    .start(start),
    .stateColumns(stateColumns),
    .resultColumns(resultColumns),
    .busy(busy),
    .done(done)
  );

  axiLiteReadSide #(
    .NumColumns(NumColumns)
  ) readSide (
    .clk(clk),
    .reset(reset),
    .araddr(araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rresp(rresp),
    .rvalid(rvalid),
    .rready(rready),
    .stateColumns(stateColumns),
    .resultColumns(resultColumns),
    .busy(busy),
    .done(done)
  );

endmodule

// File: src/axiLiteReadSide.sv
`timescale 1ns/1ps

module axiLiteReadSide #(
  parameter int NumColumns = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic [invMixPkg::AxiAddrWidth-1:0] araddr,
  input  logic arvalid,
  output logic arready,
  output logic [invMixPkg::AxiDataWidth-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input  logic rready,
  input  logic [NumColumns*invMixPkg::ColumnWidth-1:0] stateColumns,
  input  logic [NumColumns*invMixPkg::ColumnWidth-1:0] resultColumns,
  input  logic busy,
  input  logic done
);
  import invMixPkg::*;

  logic [AxiAddrWidth-3:0] wordAddr;
  logic [AxiDataWidth-1:0] readWord;
  logic [1:0] readResp;

  assign wordAddr = araddr[AxiAddrWidth-1:2];

  // unmapped words read as zero with a slave error.
  always_comb begin
    readWord = '0;
    readResp = RespSlvErr;
    for (int i = 0; i < NumColumns; i++) begin
      if (wordAddr == StateBase + i) begin
        readWord = stateColumns[i*ColumnWidth +: ColumnWidth];
        readResp = RespOkay;
      end
      if (wordAddr == ResultBase + i) begin
        readWord = resultColumns[i*ColumnWidth +: ColumnWidth];
        readResp = RespOkay;
      end
    end
    if (wordAddr == StatusAddr) begin
      readWord = {{(AxiDataWidth - 2){1'b0}}, done, busy};
      readResp = RespOkay;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
    end
  end

  // data and response stay frozen while the master holds rready low.
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
      rdata <= '0;
      rresp <= RespOkay;
    end else if (arready && arvalid) begin
      rvalid <= 1'b1;
      rdata <= readWord;
      rresp <= readResp;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

// File: src/axiLiteWriteSide.sv
`timescale 1ns/1ps

module axiLiteWriteSide #(
  parameter int NumColumns = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic [invMixPkg::AxiAddrWidth-1:0] awaddr,
  input  logic awvalid,
  output logic awready,
  input  logic [invMixPkg::AxiDataWidth-1:0] wdata,
  // byte strobes are ignored and every write updates the full word.
  input  logic [3:0] wstrb,
  input  logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input  logic bready,
  output logic [NumColumns*invMixPkg::ColumnWidth-1:0] stateColumns,
  output logic start
);
  import invMixPkg::*;

  logic [AxiAddrWidth-3:0] wordAddr;
  logic writeAccept;
  logic stateHit;
  logic controlHit;

  assign wordAddr = awaddr[AxiAddrWidth-1:2];
  assign writeAccept = awready && awvalid && wready && wvalid;
  assign controlHit = (wordAddr == ControlAddr);

  always_comb begin
    stateHit = 1'b0;
    for (int i = 0; i < NumColumns; i++) begin
      if (wordAddr == StateBase + i) begin
        stateHit = 1'b1;
      end
    end
  end

  // the start pulse is high in the very cycle the control write is taken.
  assign start = writeAccept && controlHit && wdata[0];

  // address and data are taken together, one write at a time.
  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !bvalid && !awready;
    end
  end

  assign wready = awready;

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      bresp <= RespOkay;
    end else if (writeAccept) begin
      bvalid <= 1'b1;
      bresp <= (stateHit || controlHit) ? RespOkay : RespSlvErr;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stateColumns <= '0;
    end else if (writeAccept) begin
      for (int i = 0; i < NumColumns; i++) begin
        if (wordAddr == StateBase + i) begin
          stateColumns[i*ColumnWidth +: ColumnWidth] <= wdata;
        end
      end
    end
  end

endmodule

// File: src/invMixEngine.sv
`timescale 1ns/1ps

module invMixEngine #(
  parameter int NumColumns = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic [NumColumns*invMixPkg::ColumnWidth-1:0] stateColumns,
  output logic [NumColumns*invMixPkg::ColumnWidth-1:0] resultColumns,
  output logic busy,
  output logic done
);
  import invMixPkg::*;

  localparam int CountWidth = $clog2(NumColumns);
  localparam logic [CountWidth-1:0] LastColumn = CountWidth'(NumColumns - 1);

  logic [NumColumns*ColumnWidth-1:0] workColumns;
  logic [CountWidth-1:0] columnIndex;
  logic [ColumnWidth-1:0] currentColumn;
  logic [ColumnWidth-1:0] mixedColumn;

  assign currentColumn = workColumns[columnIndex*ColumnWidth +: ColumnWidth];

  invMixColumn columnUnit (
    .column(currentColumn),
    .mixedColumn(mixedColumn)
  );

  // a start is honored only when idle. The state is copied so that later
  // register writes cannot disturb the run in progress.
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      columnIndex <= '0;
      workColumns <= '0;
      resultColumns <= '0;
    end else if (start && !busy) begin
      busy <= 1'b1;
      done <= 1'b0;
      columnIndex <= '0;
      workColumns <= stateColumns;
    end else if (busy) begin
      resultColumns[columnIndex*ColumnWidth +: ColumnWidth] <= mixedColumn;
      if (columnIndex == LastColumn) begin
        busy <= 1'b0;
        done <= 1'b1;
        columnIndex <= '0;
      end else begin
        columnIndex <= columnIndex + 1'b1;
      end
    end
  end

endmodule

// File: src/invMixColumn.sv
`timescale 1ns/1ps

module invMixColumn (
  input  logic [invMixPkg::ColumnWidth-1:0] column,
  output logic [invMixPkg::ColumnWidth-1:0] mixedColumn
);
  import invMixPkg::*;

  logic [ByteWidth-1:0] b0;
  logic [ByteWidth-1:0] b1;
  logic [ByteWidth-1:0] b2;
  logic [ByteWidth-1:0] b3;

  // byte 0 of the column sits in the top byte of the word.
  assign b0 = column[31:24];
  assign b1 = column[23:16];
  assign b2 = column[15:8];
  assign b3 = column[7:0];

  // each output row is the 14 11 13 9 row rotated one place right.
  assign mixedColumn[31:24] = gfMul14(b0) ^ gfMul11(b1) ^ gfMul13(b2) ^ gfMul9(b3);
  assign mixedColumn[23:16] = gfMul9(b0) ^ gfMul14(b1) ^ gfMul11(b2) ^ gfMul13(b3);
  assign mixedColumn[15:8] = gfMul13(b0) ^ gfMul9(b1) ^ gfMul14(b2) ^ gfMul11(b3);
  assign mixedColumn[7:0] = gfMul11(b0) ^ gfMul13(b1) ^ gfMul9(b2) ^ gfMul14(b3);

endmodule

// File: src/invMixPkg.sv
package invMixPkg;

  localparam int ByteWidth = 8;
  localparam int ColumnWidth = 32;

  localparam int AxiAddrWidth = 8;
  localparam int AxiDataWidth = 32;

  // the register map counts in 32-bit word indices.
  localparam int StateBase = 0;
  localparam int ResultBase = 8;
  localparam int ControlAddr = 16;
  localparam int StatusAddr = 17;

  localparam logic [1:0] RespOkay = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // low byte of the AES field polynomial x^8 + x^4 + x^3 + x + 1.
  localparam logic [ByteWidth-1:0] ReducePoly = 8'h1b;

  function automatic logic [ByteWidth-1:0] gfDouble(input logic [ByteWidth-1:0] value);
    logic [ByteWidth-1:0] shifted;
    shifted = {value[ByteWidth-2:0], 1'b0};
    return value[ByteWidth-1] ? (shifted ^ ReducePoly) : shifted;
  endfunction

  function automatic logic [ByteWidth-1:0] gfMul9(input logic [ByteWidth-1:0] value);
    logic [ByteWidth-1:0] times8;
    times8 = gfDouble(gfDouble(gfDouble(value)));
    return times8 ^ value;
  endfunction

  function automatic logic [ByteWidth-1:0] gfMul11(input logic [ByteWidth-1:0] value);
    logic [ByteWidth-1:0] times2;
    logic [ByteWidth-1:0] times8;
    times2 = gfDouble(value);
    times8 = gfDouble(gfDouble(times2));
    return times8 ^ times2 ^ value;
  endfunction

  function automatic logic [ByteWidth-1:0] gfMul13(input logic [ByteWidth-1:0] value);
    logic [ByteWidth-1:0] times4;
    logic [ByteWidth-1:0] times8;
    times4 = gfDouble(gfDouble(value));
    times8 = gfDouble(times4);
    return times8 ^ times4 ^ value;
  endfunction

  function automatic logic [ByteWidth-1:0] gfMul14(input logic [ByteWidth-1:0] value);
    logic [ByteWidth-1:0] times2;
    logic [ByteWidth-1:0] times4;
    logic [ByteWidth-1:0] times8;
    times2 = gfDouble(value);
    times4 = gfDouble(times2);
    times8 = gfDouble(times4);
    return times8 ^ times4 ^ times2;
  endfunction

endpackage
